/* bubble_defines.svh */
`ifndef BUBBLE_DEFINES_SVH
`define BUBBLE_DEFINES_SVH

// Bubble buffer geometry
`define BUBBLE_ADDR_W   11
`define BUBBLE_DEPTH    2048

`define STROBE_CNT_W    14      // Data strobe counter, all ones when idle
`define POSITION_W      12
`define POSITION_COUNT  2053    // Positions 0 to 2052

// Frame schedule in data strobes
`define PAGE_START      201     // Page frame anchor
`define BOOT_START      5285    // Bootloader frame anchor
`define PAGE_WORDS      512
`define BOOT_WORDS      1272
`define BOOT_TAIL       1308    // Zero strobes after bootloader data

`endif

/* bubble_pkg.sv */
`include "bubble_defines.svh"

package bubble_pkg;

    // Encoded as {pageSelect, bubbleAccess, positionLatch}
    typedef enum logic [2:0] {
        initialStandby   = 3'b000,
        bootloaderAccess = 3'b010,
        normalStandby    = 3'b100,
        pageAccess       = 3'b110,
        pageLatch        = 3'b111
    } accessState_t;

    typedef enum logic [2:0] {
        fetchIdle    = 3'd0,     // Pointer back to all ones
        fetchStep    = 3'd1,
        fetchRead    = 3'd2,
        outIdleHigh  = 3'd3,
        outEmit      = 3'd4,     // Inverted buffer word
        outPattern01 = 3'd5,
        outPattern11 = 3'd6,
        outHold      = 3'd7
    } seqCmd_t;

    typedef union packed {
        logic [1:0] raw;         // Loader view
        struct packed {
            logic odd;
            logic even;
        } pair;                  // Sequencer view
    } bubbleWord_u;

    typedef struct packed {
        logic pageSelect;
        logic bubbleAccess;
        logic positionLatch;
    } timingIn_t;

    typedef struct packed {
        logic [`BUBBLE_ADDR_W-1:0] address;
        bubbleWord_u               data;
        logic                      writeEnableN;
    } bufferWrite_t;

    typedef struct packed {
        logic odd;
        logic even;
    } bubbleOut_t;

endpackage

/* accessStateTracker.sv */
`timescale 1ns/1ps

module accessStateTracker
(
    input  logic                  bubbleBufferWriteClock,
    input  logic                  rstN,
    input  bubble_pkg::timingIn_t timing,
    output logic                  loadBootloader,
    output logic                  loadPage
);

    bubble_pkg::accessState_t state;
    logic [2:0]               code;

    assign code = timing;    // Same bit order as the state codes

    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!rstN)
        begin
            state          <= bubble_pkg::initialStandby;
            loadBootloader <= 1'b1;
            loadPage       <= 1'b1;
        end
        else
        begin
            case (code)
                bubble_pkg::initialStandby:
                begin
                    if (state != bubble_pkg::pageLatch)    // Latch to standby is a glitch
                    begin
                        state          <= bubble_pkg::initialStandby;
                        loadBootloader <= 1'b1;
                        loadPage       <= 1'b1;
                    end
                end
                bubble_pkg::bootloaderAccess:
                begin
                    if (state != bubble_pkg::pageAccess && state != bubble_pkg::pageLatch)
                    begin
                        state          <= bubble_pkg::bootloaderAccess;
                        loadBootloader <= 1'b0;
                        loadPage       <= 1'b1;
                    end
                end
                bubble_pkg::normalStandby:
                begin
                    if (state != bubble_pkg::pageLatch)
                    begin
                        state          <= bubble_pkg::normalStandby;
                        loadBootloader <= 1'b1;
                        loadPage       <= 1'b1;
                    end
                end
                bubble_pkg::pageAccess:
                begin
                    state <= bubble_pkg::pageAccess;    // Strobes carry over
                end
                bubble_pkg::pageLatch:
                begin
                    // Page latch is reachable from page access only
                    if (state == bubble_pkg::pageAccess || state == bubble_pkg::pageLatch)
                    begin
                        state          <= bubble_pkg::pageLatch;
                        loadBootloader <= 1'b1;
                        loadPage       <= 1'b0;
                    end
                end
                default:
                begin
                    state <= state;    // Latch without access
                end
            endcase
        end
    end

endmodule

/* bubbleBuffer.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module bubbleBuffer
(
    input  logic                      bubbleBufferWriteClock,
    input  bubble_pkg::bufferWrite_t  bufWrite,
    input  logic                      readEnable,
    input  logic [`BUBBLE_ADDR_W-1:0] readAddress,
    output bubble_pkg::bubbleWord_u   readWord
);

    logic [$bits(bubble_pkg::bubbleWord_u)-1:0] mem [`BUBBLE_DEPTH];

    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!bufWrite.writeEnableN)
        begin
            mem[bufWrite.address] <= bufWrite.data.raw;    // Flash loader side
        end
    end

    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (readEnable)
        begin
            readWord.raw <= mem[readAddress];
        end
    end

endmodule

/* outputSequencer.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module outputSequencer
(
    input  logic                      bubbleBufferWriteClock,
    input  logic                      rstN,
    input  logic                      dataStrobe,
    input  logic                      loadBootloader,
    input  logic                      loadPage,
    input  bubble_pkg::bubbleWord_u   readWord,
    output logic                      readEnable,
    output logic [`BUBBLE_ADDR_W-1:0] readAddress,
    output logic                      positionClear,
    output bubble_pkg::bubbleOut_t    bubbleOut
);

    localparam int cntW = `STROBE_CNT_W;

    localparam logic [cntW-1:0] bootPattern01 = cntW'(`BOOT_START - 6);
    localparam logic [cntW-1:0] bootStep      = cntW'(`BOOT_START - 4);
    localparam logic [cntW-1:0] bootRead      = cntW'(`BOOT_START - 3);
    localparam logic [cntW-1:0] bootDataFirst = cntW'(`BOOT_START - 2);
    localparam logic [cntW-1:0] bootDataLast  = cntW'(`BOOT_START - 3 + 2 * `BOOT_WORDS);
    localparam logic [cntW-1:0] bootTailLast  =
        cntW'(`BOOT_START - 3 + 2 * `BOOT_WORDS + `BOOT_TAIL);
    localparam logic [cntW-1:0] pageStep      = cntW'(`PAGE_START - 4);
    localparam logic [cntW-1:0] pageRead      = cntW'(`PAGE_START - 3);
    localparam logic [cntW-1:0] pageDataFirst = cntW'(`PAGE_START - 2);
    localparam logic [cntW-1:0] pageDataLast  = cntW'(`PAGE_START - 3 + 2 * `PAGE_WORDS);

    logic [cntW-1:0]           strobeCount;
    logic [cntW-1:0]           nextCount;
    logic                      frameActive;
    logic                      strobeDly;
    bubble_pkg::seqCmd_t       fetchNext;
    bubble_pkg::seqCmd_t       outNext;
    bubble_pkg::seqCmd_t       fetchCmd;
    bubble_pkg::seqCmd_t       outCmd;
    logic [`BUBBLE_ADDR_W-1:0] readPointer;

    assign frameActive = loadBootloader ^ loadPage;    // Exactly one load strobe low
    assign nextCount   = strobeCount + cntW'(1);       // All ones wraps to 0

    // Schedule lookup for the value this strobe gives the counter
    always_comb
    begin
        fetchNext = bubble_pkg::fetchIdle;
        outNext   = bubble_pkg::outIdleHigh;
        if (frameActive && !loadBootloader)
        begin
            if (nextCount >= bootPattern01 && nextCount < bootStep)
            begin
                outNext = bubble_pkg::outPattern01;
            end
            else if (nextCount == bootStep || nextCount == bootRead)
            begin
                fetchNext = (nextCount == bootStep) ? bubble_pkg::fetchStep : bubble_pkg::fetchRead;
                outNext   = bubble_pkg::outPattern11;
            end
            else if (nextCount >= bootDataFirst && nextCount <= bootDataLast)
            begin
                if (nextCount[0] == bootDataFirst[0])    // Emit phase
                begin
                    fetchNext = bubble_pkg::fetchStep;
                    outNext   = bubble_pkg::outEmit;
                end
                else
                begin
                    fetchNext = bubble_pkg::fetchRead;
                    outNext   = bubble_pkg::outHold;
                end
            end
            else if (nextCount > bootDataLast && nextCount <= bootTailLast)
            begin
                outNext = bubble_pkg::outPattern11;    // Zero tail
            end
        end
        else if (frameActive)
        begin
            if (nextCount == pageStep)
            begin
                fetchNext = bubble_pkg::fetchStep;
            end
            else if (nextCount == pageRead)
            begin
                fetchNext = bubble_pkg::fetchRead;
            end
            else if (nextCount >= pageDataFirst && nextCount <= pageDataLast)
            begin
                if (nextCount[0] == pageDataFirst[0])
                begin
                    fetchNext = bubble_pkg::fetchStep;
                    outNext   = bubble_pkg::outEmit;
                end
                else
                begin
                    fetchNext = bubble_pkg::fetchRead;
                    outNext   = bubble_pkg::outHold;
                end
            end
        end
    end

    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!rstN)
        begin
            strobeCount <= '1;
            strobeDly   <= 1'b0;
            fetchCmd    <= bubble_pkg::fetchIdle;
            outCmd      <= bubble_pkg::outIdleHigh;
        end
        else
        begin
            strobeDly <= dataStrobe;
            if (!frameActive)
            begin
                strobeCount <= '1;
            end
            else if (dataStrobe)
            begin
                strobeCount <= nextCount;
            end
            if (dataStrobe)
            begin
                fetchCmd <= fetchNext;
                outCmd   <= outNext;
            end
        end
    end

    // Fetch executer, one cycle after the strobe
    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!rstN)
        begin
            readPointer <= '1;
        end
        else if (strobeDly)
        begin
            case (fetchCmd)
                bubble_pkg::fetchIdle: readPointer <= '1;
                bubble_pkg::fetchStep: readPointer <= readPointer + 1'b1;    // Wraps at top
                default:               readPointer <= readPointer;
            endcase
        end
    end

    assign readEnable    = strobeDly && (fetchCmd == bubble_pkg::fetchRead);
    assign readAddress   = readPointer;
    assign positionClear = (strobeCount == bootRead) || (strobeCount == bootDataFirst);

    // Output register
    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!rstN)
        begin
            bubbleOut <= '1;
        end
        else if (strobeDly)
        begin
            case (outCmd)
                bubble_pkg::outEmit:
                begin
                    bubbleOut.odd  <= ~readWord.pair.odd;
                    bubbleOut.even <= ~readWord.pair.even;
                end
                bubble_pkg::outPattern01:
                begin
                    bubbleOut.odd  <= 1'b1;
                    bubbleOut.even <= 1'b0;
                end
                bubble_pkg::outPattern11: bubbleOut <= '0;    // Inverted 11 on the lines
                bubble_pkg::outHold:      bubbleOut <= bubbleOut;
                default:                  bubbleOut <= '1;
            endcase
        end
    end

endmodule

/* positionCounter.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module positionCounter
(
    input  logic                   bubbleBufferWriteClock,
    input  logic                   rstN,
    input  logic                   positionChange,
    input  logic                   positionClear,
    output logic [`POSITION_W-1:0] position
);

    localparam int posW = `POSITION_W;
    localparam logic [posW-1:0] lastPosition = posW'(`POSITION_COUNT - 1);

    always_ff @(posedge bubbleBufferWriteClock)
    begin
        if (!rstN)
        begin
            position <= '0;
        end
        else if (positionClear)
        begin
            position <= '0;    // Realign at bootloader start
        end
        else if (positionChange)
        begin
            if (position == lastPosition)
            begin
                position <= '0;
            end
            else
            begin
                position <= position + 1'b1;
            end
        end
    end

endmodule

/* bubbleInterface.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module bubbleInterface
(
    input  logic                     bubbleBufferWriteClock,
    input  logic                     rstN,
    input  bubble_pkg::timingIn_t    timing,
    input  logic                     dataStrobe,
    input  logic                     positionChange,
    input  bubble_pkg::bufferWrite_t bufWrite,
    output logic                     loadBootloader,
    output logic                     loadPage,
    output logic                     convert,
    output logic [`POSITION_W-1:0]   bubblePosition,
    output bubble_pkg::bubbleOut_t   bubbleOut
);

    logic                      readEnable;
    logic [`BUBBLE_ADDR_W-1:0] readAddress;
    bubble_pkg::bubbleWord_u   readWord;
    logic                      positionClear;

    assign convert = timing.positionLatch;    // To the page converter

    accessStateTracker accessTracker
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .rstN                   (rstN),
        .timing                 (timing),
        .loadBootloader         (loadBootloader),
        .loadPage               (loadPage)
    );

    bubbleBuffer buffer
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .bufWrite               (bufWrite),
        .readEnable             (readEnable),
        .readAddress            (readAddress),
        .readWord               (readWord)
    );

    outputSequencer sequencer
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .rstN                   (rstN),
        .dataStrobe             (dataStrobe),
        .loadBootloader         (loadBootloader),
        .loadPage               (loadPage),
        .readWord               (readWord),
        .readEnable             (readEnable),
        .readAddress            (readAddress),
        .positionClear          (positionClear),
        .bubbleOut              (bubbleOut)
    );

    positionCounter positionCount
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .rstN                   (rstN),
        .positionChange         (positionChange),
        .positionClear          (positionClear),
        .position               (bubblePosition)
    );

endmodule

/* bubbleInterface_props.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module bubbleInterface_props
(
    input logic                   bubbleBufferWriteClock,
    input logic                   rstN,
    input logic                   loadBootloader,
    input logic                   loadPage,
    input logic [`POSITION_W-1:0] bubblePosition
);

    strobesExclusive: assert property (@(posedge bubbleBufferWriteClock) disable iff (!rstN)
        loadBootloader || loadPage)
        else $error("loadBootloader and loadPage low together");

    strobesHighAfterReset: assert property (@(posedge bubbleBufferWriteClock)
        !rstN |=> loadBootloader && loadPage)
        else $error("Load strobes not high after reset");

    positionInRange: assert property (@(posedge bubbleBufferWriteClock) disable iff (!rstN)
        bubblePosition < `POSITION_COUNT)
        else $error("bubblePosition beyond the last position");

endmodule

bind bubbleInterface bubbleInterface_props props
(
    .bubbleBufferWriteClock (bubbleBufferWriteClock),
    .rstN                   (rstN),
    .loadBootloader         (loadBootloader),
    .loadPage               (loadPage),
    .bubblePosition         (bubblePosition)
);

/* bubbleChecker.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module bubbleChecker
(
    input  logic                     bubbleBufferWriteClock,
    input  logic                     rstN,
    input  bubble_pkg::bufferWrite_t bufWrite,
    input  bubble_pkg::timingIn_t    timing,
    input  logic                     dataStrobe,
    input  logic                     loadBootloader,
    input  logic                     loadPage,
    input  logic                     convert,
    input  logic [`POSITION_W-1:0]   bubblePosition,
    input  bubble_pkg::bubbleOut_t   bubbleOut,
    input  logic [1:0]               frameMode,
    input  logic                     checkReq,
    input  logic                     checkKind,
    input  logic [15:0]              checkExp,
    input  logic                     testDone,
    input  logic [7:0]               testId,
    input  logic                     runDone,
    output int                       errorCount
);

    logic [1:0] mirror [`BUBBLE_DEPTH];    // Copy of the loader writes
    int         frameCount = -1;
    int         checks = 0;
    int         tests = 0;
    int         testChecks = 0;
    int         testErrors = 0;
    logic       lastLatch = 1'b0;          // Latch level seen on the previous edge

    initial errorCount = 0;

    // Pair on the lines after the strobe that set the counter to c
    function automatic logic [1:0] expectedPair(input logic [1:0] mode, input int c);
        int bootData;
        int pageData;
        bootData = `BOOT_START - 2;    // Words start two strobes ahead of the anchor
        pageData = `PAGE_START - 2;
        if (mode == 2'd1 && c >= `BOOT_START - 6 && c < `BOOT_START - 4)
            return 2'b10;    // Odd high, even low
        if (mode == 2'd1 && c >= `BOOT_START - 4 && c < bootData)
            return 2'b00;
        if (mode == 2'd1 && c >= bootData && c < bootData + 2 * `BOOT_WORDS)
            return ~mirror[(c - bootData) / 2];
        if (mode == 2'd1 && c >= bootData + 2 * `BOOT_WORDS
            && c < bootData + 2 * `BOOT_WORDS + `BOOT_TAIL)
            return 2'b00;    // Zero tail
        if (mode == 2'd2 && c >= pageData && c < pageData + 2 * `PAGE_WORDS)
            return ~mirror[(c - pageData) / 2];
        return 2'b11;
    endfunction

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        checks++;
        testChecks++;
        if (actual !== expected)
        begin
            errorCount++;
            testErrors++;
            $display("CHECK FAILED test %0d %s: expected %0h, got %0h",
                     testId, name, expected, actual);
        end
    endtask

    always @(posedge bubbleBufferWriteClock)
    begin
        if (!bufWrite.writeEnableN)
            mirror[bufWrite.address] = bufWrite.data.raw;
        if (!rstN || frameMode == 2'd0)
            frameCount = -1;
        if (rstN && dataStrobe)
        begin
            compare("bubbleOut", expectedPair(frameMode, frameCount), bubbleOut);
            if (frameMode != 2'd0)
                frameCount++;
        end
        // Convert follows the latch level in the same cycle
        if (rstN && timing.positionLatch !== lastLatch)
            compare("convert", timing.positionLatch, convert);
        lastLatch = timing.positionLatch;
        if (checkReq && checkKind)
            compare("bubblePosition", checkExp, bubblePosition);
        else if (checkReq)
            compare("loadBootloader/loadPage", checkExp, {loadBootloader, loadPage});
        if (testDone)
        begin
            $display("Test %0d finished: %0d checks, %0d errors", testId, testChecks, testErrors);
            tests++;
            testChecks = 0;
            testErrors = 0;
        end
        if (runDone)
            $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errorCount);
    end

endmodule

/* tbBubbleInterface.sv */
`timescale 1ns/1ps
`include "bubble_defines.svh"

module tbBubbleInterface;

    localparam int recWords = 7;    // id scenario spacing count nVisit visits expected
    localparam int maxRecs  = 16;

    logic                     bubbleBufferWriteClock;
    logic                     rstN;
    bubble_pkg::timingIn_t    timing;
    logic                     dataStrobe;
    logic                     positionChange;
    bubble_pkg::bufferWrite_t bufWrite;
    logic                     loadBootloader;
    logic                     loadPage;
    logic                     convert;
    logic [`POSITION_W-1:0]   bubblePosition;
    bubble_pkg::bubbleOut_t   bubbleOut;
    logic [1:0]               frameMode;    // 0 idle, 1 bootloader, 2 page
    logic                     checkReq;
    logic                     checkKind;
    logic [15:0]              checkExp;
    logic                     testDone;
    logic [7:0]               testId;
    logic                     runDone;
    int                       errorCount;
    logic [31:0]              records [recWords * maxRecs];
    logic [31:0]              lfsrState = 32'h476c_875a;
    int                       limitCycles = 0;
    logic                     loaded = 1'b0;

    bubbleInterface UUT
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .rstN                   (rstN),
        .timing                 (timing),
        .dataStrobe             (dataStrobe),
        .positionChange         (positionChange),
        .bufWrite               (bufWrite),
        .loadBootloader         (loadBootloader),
        .loadPage               (loadPage),
        .convert                (convert),
        .bubblePosition         (bubblePosition),
        .bubbleOut              (bubbleOut)
    );

    bubbleChecker outChecker
    (
        .bubbleBufferWriteClock (bubbleBufferWriteClock),
        .rstN                   (rstN),
        .bufWrite               (bufWrite),
        .timing                 (timing),
        .dataStrobe             (dataStrobe),
        .loadBootloader         (loadBootloader),
        .loadPage               (loadPage),
        .convert                (convert),
        .bubblePosition         (bubblePosition),
        .bubbleOut              (bubbleOut),
        .frameMode              (frameMode),
        .checkReq               (checkReq),
        .checkKind              (checkKind),
        .checkExp               (checkExp),
        .testDone               (testDone),
        .testId                 (testId),
        .runDone                (runDone),
        .errorCount             (errorCount)
    );

    initial
    begin
        bubbleBufferWriteClock = 1'b0;
        forever #4 bubbleBufferWriteClock = ~bubbleBufferWriteClock;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic nextWord(output logic [1:0] word);
        for (int b = 0; b < 2; b++)
        begin
            word[b]   = lfsrState[0];    // One step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge bubbleBufferWriteClock);
    endtask

    // One code per nibble with the first state in the highest used nibble
    task automatic visitStates(input int n, input logic [31:0] codes);
        for (int i = n - 1; i >= 0; i--)
        begin
            @(posedge bubbleBufferWriteClock);
            timing <= bubble_pkg::timingIn_t'(codes[4 * i +: 3]);
            waitCycles(3);
        end
    endtask

    task automatic pulseTrain(input logic toPosition, input int count, input int spacing);
        repeat (count)
        begin
            @(posedge bubbleBufferWriteClock);
            if (toPosition)
                positionChange <= 1'b1;
            else
                dataStrobe <= 1'b1;
            @(posedge bubbleBufferWriteClock);
            positionChange <= 1'b0;
            dataStrobe     <= 1'b0;
            waitCycles(spacing - 2);
        end
    endtask

    task automatic writeWords(input int count, input logic enableN);
        logic [1:0] word;
        for (int a = 0; a < count; a++)
        begin
            nextWord(word);
            @(posedge bubbleBufferWriteClock);
            bufWrite.address      <= a[`BUBBLE_ADDR_W-1:0];
            bufWrite.data.raw     <= word;
            bufWrite.writeEnableN <= enableN;
        end
        @(posedge bubbleBufferWriteClock);
        bufWrite.writeEnableN <= 1'b1;
    endtask

    task automatic requestCheck(input logic kind, input logic [15:0] value);
        @(posedge bubbleBufferWriteClock);
        checkReq  <= 1'b1;
        checkKind <= kind;    // 0 load strobes, 1 position
        checkExp  <= value;
        @(posedge bubbleBufferWriteClock);
        checkReq  <= 1'b0;
    endtask

    task automatic finishTest();
        @(posedge bubbleBufferWriteClock);
        testDone <= 1'b1;
        @(posedge bubbleBufferWriteClock);
        testDone <= 1'b0;
    endtask

    initial
    begin
        int          base;
        int          id;
        int          scen;
        int          spacing;
        int          count;
        int          nVisit;
        logic [31:0] visits;
        logic [31:0] expected;
        rstN           <= 1'b0;
        timing         <= '0;
        dataStrobe     <= 1'b0;
        positionChange <= 1'b0;
        bufWrite       <= {{`BUBBLE_ADDR_W{1'b0}}, 2'b00, 1'b1};
        frameMode      <= 2'd0;
        checkReq       <= 1'b0;
        checkKind      <= 1'b0;
        checkExp       <= '0;
        testDone       <= 1'b0;
        testId         <= '0;
        runDone        <= 1'b0;
        foreach (records[i])
            records[i] = '0;    // Id 0 ends the list
        $readmemh("bubble_input.txt", records);
        limitCycles = `BUBBLE_DEPTH + 2000;
        for (int r = 0; r < maxRecs; r++)
        begin
            base = r * recWords;
            if (records[base] != 0)
                limitCycles += records[base + 2] * records[base + 3] + 8 * records[base + 4] + 40;
        end
        loaded = 1'b1;
        waitCycles(5);
        rstN <= 1'b1;
        writeWords(`BUBBLE_DEPTH, 1'b0);    // Fill the whole buffer
        for (int r = 0; r < maxRecs; r++)
        begin
            base = r * recWords;
            if (records[base] != 0)
            begin
                id       = records[base];
                scen     = records[base + 1];
                spacing  = records[base + 2];
                count    = records[base + 3];
                nVisit   = records[base + 4];
                visits   = records[base + 5];
                expected = records[base + 6];
                @(posedge bubbleBufferWriteClock);
                testId <= id[7:0];
                visitStates(nVisit, visits);
                case (scen)
                    0: requestCheck(1'b0, expected[15:0]);
                    1, 2:
                    begin
                        requestCheck(1'b0, (scen == 1) ? 16'h1 : 16'h2);
                        @(posedge bubbleBufferWriteClock);
                        frameMode <= scen[1:0];
                        waitCycles(2);
                        pulseTrain(1'b0, count, spacing);
                        waitCycles(spacing);
                        frameMode <= 2'd0;
                        visitStates(scen, 32'h64);    // Page leaves through page access
                        if (scen == 1)
                            requestCheck(1'b1, expected[15:0]);
                    end
                    3:
                    begin
                        pulseTrain(1'b1, count, spacing);
                        requestCheck(1'b1, expected[15:0]);
                    end
                    4: writeWords(count, 1'b1);
                    default: pulseTrain(1'b0, count, spacing);
                endcase
                finishTest();
            end
        end
        @(posedge bubbleBufferWriteClock);
        runDone <= 1'b1;
        @(posedge bubbleBufferWriteClock);
        runDone <= 1'b0;
        waitCycles(2);
        if (errorCount == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial
    begin
        wait (loaded);
        repeat (limitCycles) @(posedge bubbleBufferWriteClock);
        $display("Watchdog timeout: tests did not finish within %0d cycles", limitCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* bubble_input.txt */
// id scenario spacing count nVisit visits expected, all hex; visits are timing codes
// scenario 0 strobe check, 1 bootloader frame, 2 page frame, 3 position pulses, 4 writes
// with writeEnableN high, 5 idle strobes; expected is {loadBootloader,loadPage} or position
01 5 4 20   1 4     0
02 3 4 80A  1 4     5
03 1 4 23B4 1 2     0
04 2 5 4CE  3 467   0
05 0 4 0    2 21    1
06 0 4 0    5 04674 2
07 0 4 0    4 6462  3
08 4 4 200  1 4     0
09 2 4 4CE  3 467   0
0A 5 6 20   1 4     0

/* sources.f */
+incdir+.
bubble_pkg.sv
accessStateTracker.sv
bubbleBuffer.sv
outputSequencer.sv
positionCounter.sv
bubbleInterface.sv
bubbleInterface_props.sv
bubbleChecker.sv
tbBubbleInterface.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbBubbleInterface
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
